// File: Makefile
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		-f project.f --top-module rename_tb -o rename_sim

run: compile
	./obj_dir/rename_sim | tee $(LOG)
	grep -qx "No errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: common/checkpoint_if.sv
`default_nettype none

interface checkpoint_if
    import rename_pkg::*;
();

    logic       save;         // One-cycle write strobe.
    page_t      save_page;
    map_table_t snapshot;     // Table before the current edge.
    page_t      restore_page;
    map_table_t restored;     // Selected page, no delay.

    // Rename table side.
    modport tbl (
        output save,
        output save_page,
        output snapshot,
        output restore_page,
        input  restored
    );

    // Checkpoint storage side.
    modport store (
        input  save,
        input  save_page,
        input  snapshot,
        input  restore_page,
        output restored
    );

endinterface

`default_nettype wire

// File: common/rename_macros.svh
`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

`default_nettype none

// Register file sizes.
`define RENAME_NUM_ARCH 32
`define RENAME_NUM_PHYS 128

// Branch checkpoints.
`define RENAME_NUM_PAGES 32

// Reserved tags, above the last physical register.
`define RENAME_TAG_NO_SRC 8'hFE
`define RENAME_TAG_NO_DEST 8'hFF

`default_nettype wire

`endif

// File: common/rename_pkg.sv
`include "rename_macros.svh"

`default_nettype none

package rename_pkg;

    typedef logic [$clog2(`RENAME_NUM_ARCH)-1:0] arch_reg_t;
    typedef logic [7:0] phys_reg_t; // Room for the reserved tags.
    typedef logic [$clog2(`RENAME_NUM_PAGES)-1:0] page_t;
    typedef logic [6:0] opcode_t;

    // One full architectural to physical mapping.
    typedef phys_reg_t map_table_t [`RENAME_NUM_ARCH];

    typedef enum logic [1:0] {
        SRC_NONE,
        SRC_ONE,
        SRC_TWO
    } src_class_t;

    // RV32I major opcodes.
    localparam opcode_t OPC_NONE   = 7'b0000000;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_SYSTEM = 7'b1110011;

endpackage

`default_nettype wire

// File: project.f
+incdir+common
common/rename_pkg.sv
common/checkpoint_if.sv
rtl/free_list.sv
rename/checkpoint_store.sv
rename/rename_table.sv
rtl/rename_top.sv
testbench/rename_tb.sv

// File: rename/checkpoint_store.sv
`include "rename_macros.svh"

`default_nettype none

module checkpoint_store
    import rename_pkg::*;
(
    input  logic         clk,
    checkpoint_if.store  ckpt
);

    // One saved mapping per in-flight branch.
    map_table_t pages [`RENAME_NUM_PAGES];

    // Whole page written at once.
    always_ff @(posedge clk) begin
        if (ckpt.save) begin
            for (int k = 0; k < `RENAME_NUM_ARCH; k++) begin
                pages[ckpt.save_page][k] <= ckpt.snapshot[k];
            end
        end
    end

    // Read port has no register.
    always_comb begin
        for (int k = 0; k < `RENAME_NUM_ARCH; k++) begin
            ckpt.restored[k] = pages[ckpt.restore_page][k];
        end
    end

endmodule

`default_nettype wire

// File: rename/rename_table.sv
`include "rename_macros.svh"

`default_nettype none

module rename_table
    import rename_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      recover,
    input  logic      flush,
    input  logic      in_valid,
    input  opcode_t   opcode,
    input  arch_reg_t rs1,
    input  arch_reg_t rs2,
    input  arch_reg_t rd,
    input  logic      save,
    input  logic      restore,
    input  page_t     save_page,
    input  page_t     restore_page,
    input  phys_reg_t free_tag,
    input  logic      free_empty,
    output logic      alloc,
    output logic      out_valid,
    output phys_reg_t src1_tag,
    output phys_reg_t src2_tag,
    output phys_reg_t dest_tag,
    output phys_reg_t old_tag,
    checkpoint_if.tbl ckpt
);

    map_table_t map;
    map_table_t base;       // Mapping seen by this cycle's instruction.
    src_class_t src_class;
    logic       accept;
    logic       writes_dest;
    logic       rename_dest;

    always_comb begin
        case (opcode)
            OPC_JALR, OPC_LOAD, OPC_OP_IMM, OPC_SYSTEM: src_class = SRC_ONE;
            OPC_LUI, OPC_AUIPC, OPC_JAL:                src_class = SRC_NONE;
            default:                                    src_class = SRC_TWO;
        endcase
    end

    // No destination for branches, stores, empty slots or x0.
    assign writes_dest = (opcode != OPC_BRANCH) && (opcode != OPC_STORE)
                         && (opcode != OPC_NONE) && (rd != '0);

    assign accept      = in_valid && !flush && !recover;
    assign rename_dest = accept && writes_dest && !free_empty;
    assign alloc       = rename_dest;

    // A restore takes effect under the same instruction.
    always_comb begin
        if (restore) begin
            base = ckpt.restored;
        end else begin
            base = map;
        end
    end

    assign ckpt.save         = save && !restore; // Restore wins.
    assign ckpt.save_page    = save_page;
    assign ckpt.snapshot     = map;
    assign ckpt.restore_page = restore_page;

    always_ff @(posedge clk) begin
        if (reset || recover) begin
            for (int k = 0; k < `RENAME_NUM_ARCH; k++) begin
                map[k] <= phys_reg_t'(k); // Identity mapping.
            end
            out_valid <= 1'b0;
        end else begin
            if (restore) begin
                map <= ckpt.restored;
            end
            if (rename_dest) begin
                map[rd] <= free_tag; // Lands on top of a restored page.
            end
            out_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            if (src_class == SRC_NONE) begin
                src1_tag <= `RENAME_TAG_NO_SRC;
            end else begin
                src1_tag <= base[rs1];
            end
            if (src_class == SRC_TWO) begin
                src2_tag <= base[rs2];
            end else begin
                src2_tag <= `RENAME_TAG_NO_SRC;
            end
            if (rename_dest) begin
                dest_tag <= free_tag;
                old_tag  <= base[rd]; // Freed later at commit.
            end else begin
                dest_tag <= `RENAME_TAG_NO_DEST;
                old_tag  <= `RENAME_TAG_NO_DEST;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/free_list.sv
`include "rename_macros.svh"

`default_nettype none

module free_list
    import rename_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      recover,
    input  logic      alloc,
    input  logic      release_valid,
    input  phys_reg_t release_tag,
    output phys_reg_t free_tag,
    output logic      free_empty
);

    localparam int PTR_W    = $clog2(`RENAME_NUM_PHYS);
    localparam int CNT_W    = PTR_W + 1;
    localparam int NUM_INIT = `RENAME_NUM_PHYS - `RENAME_NUM_ARCH;

    phys_reg_t        fifo [`RENAME_NUM_PHYS];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign pop  = alloc && (count != '0);
    assign push = release_valid && (count != CNT_W'(`RENAME_NUM_PHYS));

    assign free_tag   = fifo[head];
    assign free_empty = (count == '0);

    always_ff @(posedge clk) begin
        if (reset || recover) begin
            // Every tag above the architectural ones is free.
            for (int i = 0; i < NUM_INIT; i++) begin
                fifo[i] <= phys_reg_t'(i + `RENAME_NUM_ARCH);
            end
        end else if (push) begin
            fifo[tail] <= release_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || recover) begin
            head  <= '0;
            tail  <= PTR_W'(NUM_INIT);
            count <= CNT_W'(NUM_INIT);
        end else begin
            if (pop) begin
                head <= head + 1'b1; // Wraps at the buffer end.
            end
            if (push) begin
                tail <= tail + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Idle, or push and pop together.
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/rename_top.sv
`default_nettype none

module rename_top
    import rename_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      in_valid,
    input  logic      flush,
    input  logic      recover,     // Exception or mret.
    input  opcode_t   opcode,
    input  arch_reg_t rs1,
    input  arch_reg_t rs2,
    input  arch_reg_t rd,
    input  logic      save,
    input  page_t     save_page,
    input  logic      restore,
    input  page_t     restore_page,
    input  logic      release_valid,
    input  phys_reg_t release_tag,
    output logic      out_valid,
    output phys_reg_t src1_tag,
    output phys_reg_t src2_tag,
    output phys_reg_t dest_tag,
    output phys_reg_t old_tag,
    output logic      free_empty
);

    logic      alloc;
    phys_reg_t free_tag;

    checkpoint_if ckpt_if ();

    rename_table i_rename_table (
        .clk          (clk),
        .reset        (reset),
        .recover      (recover),
        .flush        (flush),
        .in_valid     (in_valid),
        .opcode       (opcode),
        .rs1          (rs1),
        .rs2          (rs2),
        .rd           (rd),
        .save         (save),
        .restore      (restore),
        .save_page    (save_page),
        .restore_page (restore_page),
        .free_tag     (free_tag),
        .free_empty   (free_empty),
        .alloc        (alloc),
        .out_valid    (out_valid),
        .src1_tag     (src1_tag),
        .src2_tag     (src2_tag),
        .dest_tag     (dest_tag),
        .old_tag      (old_tag),
        .ckpt         (ckpt_if.tbl)
    );

    checkpoint_store i_checkpoint_store (
        .clk  (clk),
        .ckpt (ckpt_if.store)
    );

    free_list i_free_list (
        .clk           (clk),
        .reset         (reset),
        .recover       (recover),
        .alloc         (alloc),
        .release_valid (release_valid),
        .release_tag   (release_tag),
        .free_tag      (free_tag),
        .free_empty    (free_empty)
    );

endmodule

`default_nettype wire

// File: testbench/rename_tb.sv
`include "rename_macros.svh"

`default_nettype none

module rename_tb
    import rename_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam int      MAX_CYCLES = 6000; // Tests take about 2500.

    typedef struct packed {
        logic      valid;
        logic      empty;
        phys_reg_t s1;
        phys_reg_t s2;
        phys_reg_t d;
        phys_reg_t o;
    } expect_t;

    logic      clk;
    logic      reset, in_valid, flush, recover, save, restore, release_valid;
    opcode_t   opcode;
    arch_reg_t rs1, rs2, rd;
    page_t     save_page, restore_page;
    phys_reg_t release_tag;
    logic      out_valid, free_empty;
    phys_reg_t src1_tag, src2_tag, dest_tag, old_tag;

    // Reference state.
    phys_reg_t m_map [`RENAME_NUM_ARCH];
    phys_reg_t m_pages [`RENAME_NUM_PAGES][`RENAME_NUM_ARCH];
    bit        m_saved [`RENAME_NUM_PAGES];
    phys_reg_t m_free [$];
    phys_reg_t m_retired [$]; // Old tags waiting to be released.
    expect_t   exp_q = '0;

    opcode_t   opc_list [11] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH,
        OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_SYSTEM, OPC_OP, OPC_NONE};
    string     cur_test = "reset";
    logic      checking = 1'b0;
    int        checks, test_errors, total_checks, total_errors, tests_done;
    int        cycle_count = 0;

    rename_top i_rename_top (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic expect_t model_step();
        expect_t   e;
        phys_reg_t view [`RENAME_NUM_ARCH];
        logic      accept;
        logic      has_dest;
        logic      push_ok;
        e = '0;
        push_ok = (m_free.size() < `RENAME_NUM_PHYS);
        if (save && !restore) begin // Captures the table before this edge.
            m_pages[save_page] = m_map;
            m_saved[save_page] = 1'b1;
        end
        if (reset || recover) begin
            foreach (m_map[k]) begin
                m_map[k] = phys_reg_t'(k);
            end
            m_free.delete();
            m_retired.delete();
            for (int t = `RENAME_NUM_ARCH; t < `RENAME_NUM_PHYS; t++) begin
                m_free.push_back(phys_reg_t'(t));
            end
        end else begin
            if (restore) begin
                view = m_pages[restore_page];
            end else begin
                view = m_map;
            end
            accept   = in_valid && !flush;
            has_dest = accept && (rd != 0) && (m_free.size() != 0)
                       && !(opcode inside {OPC_BRANCH, OPC_STORE, OPC_NONE});
            e.valid = accept;
            e.s1 = (opcode inside {OPC_LUI, OPC_AUIPC, OPC_JAL}) ? `RENAME_TAG_NO_SRC
                                                                  : view[rs1];
            e.s2 = (opcode inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_LOAD,
                    OPC_OP_IMM, OPC_SYSTEM}) ? `RENAME_TAG_NO_SRC : view[rs2];
            e.d = `RENAME_TAG_NO_DEST;
            e.o = `RENAME_TAG_NO_DEST;
            if (has_dest) begin
                e.d = m_free.pop_front();
                e.o = view[rd];
                view[rd] = e.d;
                m_retired.push_back(e.o);
            end
            m_map = view;
            if (release_valid && push_ok) begin
                m_free.push_back(release_tag);
            end
        end
        e.empty = (m_free.size() == 0);
        return e;
    endfunction

    always @(posedge clk) exp_q <= model_step();

    function automatic void report_mismatch(string sig, logic [7:0] expected,
                                            logic [7:0] actual);
        $display("Mismatch in test %s, %s: expected %0h, actual %0h",
                 cur_test, sig, expected, actual);
        test_errors++;
    endfunction

    // Outputs are stable at the falling edge.
    always @(negedge clk) begin
        if (checking) begin
            checks++;
            assert (out_valid === exp_q.valid) else begin
                report_mismatch("out_valid", 8'(exp_q.valid), 8'(out_valid));
            end
            assert (free_empty === exp_q.empty) else begin
                report_mismatch("free_empty", 8'(exp_q.empty), 8'(free_empty));
            end
            if (exp_q.valid) begin
                assert (src1_tag === exp_q.s1)
                    else report_mismatch("src1_tag", exp_q.s1, src1_tag);
                assert (src2_tag === exp_q.s2)
                    else report_mismatch("src2_tag", exp_q.s2, src2_tag);
                assert (dest_tag === exp_q.d)
                    else report_mismatch("dest_tag", exp_q.d, dest_tag);
                assert (old_tag === exp_q.o)
                    else report_mismatch("old_tag", exp_q.o, old_tag);
            end
        end
    end

    task automatic clear_inputs();
        {in_valid, flush, recover, save, restore, release_valid} = '0;
        opcode       = OPC_NONE;
        {rs1, rs2, rd} = '0;
        save_page    = '0;
        restore_page = '0;
        release_tag  = '0;
    endtask

    task automatic issue(input opcode_t op, input arch_reg_t a1, a2, d);
        @(negedge clk);
        clear_inputs();
        in_valid = 1'b1;
        opcode   = op;
        rs1      = a1;
        rs2      = a2;
        rd       = d;
    endtask

    task automatic recover_cycle();
        issue(OPC_OP, 5'd1, 5'd2, 5'd3); // Dropped by the recover.
        recover = 1'b1;
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        checks      = 0;
        test_errors = 0;
    endtask

    task automatic finish_test();
        repeat (2) begin
            @(negedge clk);
            clear_inputs();
        end
        @(posedge clk);
        $display("Test %-22s %0d checks, %0d errors", cur_test, checks, test_errors);
        total_checks += checks;
        total_errors += test_errors;
        tests_done++;
    endtask

    initial begin
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Errors found");
        $finish;
    end

    initial begin
        void'($urandom(42034));
        clear_inputs();
        reset = 1'b1;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        @(posedge clk);
        checking = 1'b1;

        start_test("reset_alloc");
        for (int i = 1; i < 9; i++) begin
            issue(OPC_OP, arch_reg_t'(i), arch_reg_t'(i + 1), arch_reg_t'(i % 3 + 1));
        end
        finish_test();

        start_test("operand_classes");
        foreach (opc_list[i]) begin
            issue(opc_list[i], 5'd7, 5'd9, 5'd11);
            issue(opc_list[i], 5'd11, 5'd12, 5'd0); // x0 destination.
        end
        finish_test();

        start_test("release_reuse");
        recover_cycle();
        for (int i = 0; i < 4; i++) begin
            issue(OPC_OP, 5'd1, 5'd2, arch_reg_t'(i + 1));
            release_valid = 1'b1; // Push and pop together.
            release_tag   = phys_reg_t'(i + 1);
        end
        for (int i = 0; i < 96; i++) begin
            issue(OPC_OP_IMM, 5'd3, 5'd0, arch_reg_t'(i % 31 + 1));
        end
        finish_test();

        start_test("checkpoint");
        recover_cycle();
        issue(OPC_OP, 5'd5, 5'd6, 5'd5);
        save      = 1'b1;
        save_page = 5'd3;
        issue(OPC_OP, 5'd4, 5'd4, 5'd4);
        save      = 1'b1;
        save_page = 5'd4;
        issue(OPC_OP, 5'd5, 5'd6, 5'd6);
        issue(OPC_LOAD, 5'd5, 5'd0, 5'd7);
        save         = 1'b1; // Loses to the restore.
        save_page    = 5'd4;
        restore      = 1'b1;
        restore_page = 5'd3;
        issue(OPC_OP, 5'd5, 5'd6, 5'd8);
        restore      = 1'b1;
        restore_page = 5'd3;
        issue(OPC_OP, 5'd7, 5'd8, 5'd5);
        issue(OPC_OP, 5'd4, 5'd5, 5'd9);
        restore      = 1'b1;
        restore_page = 5'd4;
        issue(OPC_OP, 5'd4, 5'd5, 5'd6);
        finish_test();

        start_test("flush_recover_exhaust");
        issue(OPC_OP, 5'd2, 5'd3, 5'd2);
        flush = 1'b1;
        issue(OPC_OP, 5'd2, 5'd3, 5'd3);
        recover_cycle();
        issue(OPC_OP, 5'd2, 5'd3, 5'd4);
        for (int i = 0; i < 97; i++) begin
            issue(OPC_LUI, 5'd0, 5'd0, arch_reg_t'(i % 31 + 1));
        end
        issue(OPC_JAL, 5'd0, 5'd0, 5'd10);
        issue(OPC_OP, 5'd10, 5'd1, 5'd2);
        recover_cycle();
        issue(OPC_OP, 5'd1, 5'd2, 5'd3);
        finish_test();

        start_test("random_mix");
        repeat (2000) begin
            @(negedge clk);
            clear_inputs();
            in_valid = ($urandom_range(99) < 80);
            opcode   = opc_list[$urandom_range(10)];
            rs1      = arch_reg_t'($urandom());
            rs2      = arch_reg_t'($urandom());
            rd       = arch_reg_t'($urandom());
            flush    = ($urandom_range(99) < 5);
            recover  = ($urandom_range(199) == 0);
            if (!recover && $urandom_range(99) < 6) begin
                save      = 1'b1;
                save_page = page_t'($urandom());
            end
            restore_page = page_t'($urandom());
            restore = !recover && m_saved[restore_page] && ($urandom_range(99) < 4);
            if (m_retired.size() != 0 && $urandom_range(99) < 35) begin
                release_valid = 1'b1;
                release_tag   = m_retired.pop_front();
            end
        end
        finish_test();

        $display("Tests run: %0d, checks: %0d, failures: %0d",
                 tests_done, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
